// File: Bender.yml
package:
  name: mult_pipe

sources:
  # package and interface first, then leaf modules up to the top
  - logic/mult_pkg.sv
  - logic/mult_product_if.sv
  - logic/shift_reg.sv
  - logic/math_mult_35.sv
  - logic/mult_core_stage.sv
  - logic/mult_round_sat.sv
  - logic/mult_pipe_top.sv

  - target: simulation
    files:
      - dv/mult_pipe_tb.sv

// File: all.f
logic/mult_pkg.sv
logic/mult_product_if.sv
logic/shift_reg.sv
logic/math_mult_35.sv
logic/mult_core_stage.sv
logic/mult_round_sat.sv
logic/mult_pipe_top.sv
dv/mult_pipe_tb.sv

// File: dv/mult_patterns.hex
// columns: opa opb mode tag expected_result expected_sat
// mode 0 raw, 1 round q17, 2 trunc q34, 3 round q34
00000000003 000000005 0 01 00000000000F 0
0000001FFFF 00001FFFF 0 02 0003FFFC0001 0
0000001FFFF 00001FFFF 1 03 00000001FFFE 0
0000001FFFF 00001FFFF 2 04 000000000000 0
0000001FFFF 00001FFFF 3 05 000000000001 0
00000FFFFFF 000FFFFFF 0 06 FFFFFE000001 0
00000FFFFFF 000FFFFFF 1 07 00007FFFFF00 0
00000FFFFFF 000FFFFFF 2 08 000000003FFF 0
00000FFFFFF 000FFFFFF 3 09 000000004000 0
00001000000 001000000 0 0A FFFFFFFFFFFF 1
00001000000 001000000 1 0B 000080000000 0
00001000001 000FFFFFF 0 0C FFFFFFFFFFFF 0
3FFFFFFFFFF 7FFFFFFFF 0 0D FFFFFFFFFFFF 1
3FFFFFFFFFF 7FFFFFFFF 1 0E FFFFFFFFFFFF 1
3FFFFFFFFFF 7FFFFFFFF 2 0F 000FFFFFFEFE 0
3FFFFFFFFFF 7FFFFFFFF 3 10 000FFFFFFEFE 0
00200000000 000000001 2 11 000000000000 0
00200000000 000000001 3 12 000000000001 0
001FFFFFFFF 000000001 3 13 000000000000 0
00000010000 000000001 1 14 000000000001 0
00000030000 000000001 1 15 000000000002 0
00000020001 000020001 0 16 000400040001 0
00000020001 000020001 3 17 000000000001 0
20000000000 010000000 0 18 FFFFFFFFFFFF 1
20000000000 010000000 2 19 000800000000 0
20000000000 010000000 1 1A FFFFFFFFFFFF 1
3FFFFFFFFFF 000000001 2 1B 0000000000FF 0
3FFFFFFFFFF 000000001 3 1C 000000000100 0
00000000001 7FFFFFFFF 1 1D 000000040000 0
2AAAAAAAAAA 000000003 0 1E 07FFFFFFFFFE 0
00000000003 555555555 3 1F 000000000004 0
3FFFFFFFFFF 00003FFFF 1 20 07FFFDFFFFFE 0
3FFFFFFFFFF 00003FFFF 2 21 000003FFFEFF 0
3FFFFFFFFFF 00003FFFF 3 22 000003FFFF00 0
20000000000 000040000 1 23 040000000000 0
20000000000 000040000 2 24 000002000000 0

// File: dv/mult_pipe_tb.sv
/*
 * Testbench for the scaled multiplier pipeline. Reads vectors from the
 * pattern file, issues them with random idle gaps and checks every
 * result, tag and sat flag in issue order.
 */

`timescale 1ns/10ps

module mult_pipe_tb;

  localparam int NUM_VEC       = 36;
  localparam int WORDS_PER_VEC = 6;
  localparam int CYCLE_LIMIT   = NUM_VEC * 4 + mult_pkg::PIPE_LATENCY + 20;

  logic                 clk;
  logic                 reset;
  logic                 in_valid;
  mult_pkg::opa_t       opa;
  mult_pkg::opb_t       opb;
  mult_pkg::mult_mode_e mode;
  mult_pkg::tag_t       tag;
  logic                 out_valid;
  mult_pkg::result_t    result;
  logic                 sat;
  mult_pkg::tag_t       out_tag;

  // six words per vector, same order as the file columns
  logic [47:0] pattern_mem [NUM_VEC*WORDS_PER_VEC];
  int          pending [$];
  int          value_errors;
  int          other_errors;
  int          cycle_count;
  logic [31:0] rng_state;

  mult_pipe_top mult_pipe_top_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .opa       (opa),
    .opb       (opb),
    .mode      (mode),
    .tag       (tag),
    .out_valid (out_valid),
    .result    (result),
    .sat       (sat),
    .out_tag   (out_tag)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [47:0] pattern_word(input int idx, input int col);
    return pattern_mem[idx*WORDS_PER_VEC + col];
  endfunction

  task automatic check_result(input int idx, input mult_pkg::result_t expected,
                              input mult_pkg::result_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL result vector %0d expected %h actual %h", idx, expected, actual);
    end
  endtask

  task automatic check_tag(input int idx, input mult_pkg::tag_t expected,
                           input mult_pkg::tag_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL out_tag vector %0d expected %h actual %h", idx, expected, actual);
    end
  endtask

  task automatic check_sat(input int idx, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL sat vector %0d expected %h actual %h", idx, expected, actual);
    end
  endtask

  task automatic report_counts();
    $display("value errors: %0d, other errors: %0d, vectors: %0d",
             value_errors, other_errors, NUM_VEC);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    int gap;
    reset        = 1'b1;
    in_valid     = 1'b0;
    opa          = '0;
    opb          = '0;
    mode         = mult_pkg::MODE_RAW;
    tag          = '0;
    value_errors = 0;
    other_errors = 0;
    rng_state    = 32'd93;
    $readmemh("dv/mult_patterns.hex", pattern_mem);
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    // idle after reset, monitor flags any stray out_valid
    repeat (3) @(posedge clk);
    for (int i = 0; i < NUM_VEC; i++) begin
      rng_state = xorshift32(rng_state);
      gap = int'(rng_state % 4);
      repeat (gap) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
      @(posedge clk);
      in_valid <= 1'b1;
      opa      <= mult_pkg::opa_t'(pattern_word(i, 0));
      opb      <= mult_pkg::opb_t'(pattern_word(i, 1));
      mode     <= mult_pkg::mult_mode_e'(2'(pattern_word(i, 2)));
      tag      <= mult_pkg::tag_t'(pattern_word(i, 3));
      pending.push_back(i);
    end
    @(posedge clk);
    in_valid <= 1'b0;
    while (pending.size() != 0) @(posedge clk);
    // guard window for duplicate strobes
    repeat (mult_pkg::PIPE_LATENCY + 2) @(posedge clk);
    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  ////////////////////////////////////////
  // response check, on the falling edge
  ////////////////////////////////////////

  initial begin : monitor
    int idx;
    while (reset !== 1'b0) @(posedge clk);
    forever begin
      @(negedge clk);
      if (out_valid === 1'b1) begin
        if (pending.size() == 0) begin
          other_errors++;
          $display("out_valid was high at %0t with no sample outstanding", $time);
        end else begin
          idx = pending.pop_front();
          check_result(idx, mult_pkg::result_t'(pattern_word(idx, 4)), result);
          check_tag(idx, mult_pkg::tag_t'(pattern_word(idx, 3)), out_tag);
          check_sat(idx, 1'(pattern_word(idx, 5)), sat);
        end
      end else if (out_valid !== 1'b0) begin
        other_errors++;
        $display("out_valid was unknown at %0t", $time);
      end
    end
  end

  // run length bound, counted from the end of reset
  initial begin : watchdog
    cycle_count = 0;
    while (reset !== 1'b0) @(posedge clk);
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    other_errors++;
    $display("timeout after %0d cycles with %0d samples still outstanding",
             cycle_count, pending.size());
    report_counts();
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: logic/math_mult_35.sv
/*
 * 42x35 unsigned multiply built as four cascaded limb products.
 * Fixed latency of 6 register stages, registered output, no enable.
 * Product is kept to 70 bits, so bits above that are dropped.
 */

`timescale 1ns/10ps

module math_mult_35 (
  input  logic               clk,
  input  mult_pkg::opa_t     dina,
  input  mult_pkg::opb_t     dinb,
  output mult_pkg::product_t dout
);

  // staggered operand limbs, suffix is the number of flops behind the input
  logic [mult_pkg::LIMB_LO-1:0]  a_lo_d1;
  logic [mult_pkg::LIMB_LO-1:0]  a_lo_d3;
  logic [mult_pkg::LIMB_LO-1:0]  b_lo_d1;
  logic [mult_pkg::LIMB_LO-1:0]  b_lo_d2;
  logic [mult_pkg::OPA_HI_W-1:0] a_hi_d2;
  logic [mult_pkg::OPA_HI_W-1:0] a_hi_d4;
  logic [mult_pkg::OPB_HI_W-1:0] b_hi_d3;
  logic [mult_pkg::OPB_HI_W-1:0] b_hi_d4;

  // multiplier and post-adder registers of each limb product
  logic [33:0] m0_q;
  logic [33:0] p0_q;
  logic [41:0] m1_q;
  logic [42:0] p1_q;
  logic [34:0] m2_q;
  logic [43:0] p2_q;
  logic [42:0] m3_q;
  logic [35:0] p3_q;

  ////////////////////////////////////////
  // operand staggering
  ////////////////////////////////////////

  shift_reg #(
    .WIDTH (mult_pkg::LIMB_LO),
    .DEPTH (0)
  ) shift_reg_a_lo_d1 (
    .clk  (clk),
    .ena  (1'b1),
    .din  (dina[mult_pkg::LIMB_LO-1:0]),
    .dout (a_lo_d1)
  );

  // a_lo reused two flops later by the lo x hi product
  shift_reg #(
    .WIDTH (mult_pkg::LIMB_LO),
    .DEPTH (1)
  ) shift_reg_a_lo_d3 (
    .clk  (clk),
    .ena  (1'b1),
    .din  (a_lo_d1),
    .dout (a_lo_d3)
  );

  shift_reg #(
    .WIDTH (mult_pkg::LIMB_LO),
    .DEPTH (0)
  ) shift_reg_b_lo_d1 (
    .clk  (clk),
    .ena  (1'b1),
    .din  (dinb[mult_pkg::LIMB_LO-1:0]),
    .dout (b_lo_d1)
  );

  // b_lo passed along like a B cascade
  shift_reg #(
    .WIDTH (mult_pkg::LIMB_LO),
    .DEPTH (0)
  ) shift_reg_b_lo_d2 (
    .clk  (clk),
    .ena  (1'b1),
    .din  (b_lo_d1),
    .dout (b_lo_d2)
  );

  shift_reg #(
    .WIDTH (mult_pkg::OPA_HI_W),
    .DEPTH (1)
  ) shift_reg_a_hi_d2 (
    .clk  (clk),
    .ena  (1'b1),
    .din  (dina[mult_pkg::OPA_W-1:mult_pkg::LIMB_LO]),
    .dout (a_hi_d2)
  );

  shift_reg #(
    .WIDTH (mult_pkg::OPA_HI_W),
    .DEPTH (1)
  ) shift_reg_a_hi_d4 (
    .clk  (clk),
    .ena  (1'b1),
    .din  (a_hi_d2),
    .dout (a_hi_d4)
  );

  shift_reg #(
    .WIDTH (mult_pkg::OPB_HI_W),
    .DEPTH (2)
  ) shift_reg_b_hi_d3 (
    .clk  (clk),
    .ena  (1'b1),
    .din  (dinb[mult_pkg::OPB_W-1:mult_pkg::LIMB_LO]),
    .dout (b_hi_d3)
  );

  shift_reg #(
    .WIDTH (mult_pkg::OPB_HI_W),
    .DEPTH (0)
  ) shift_reg_b_hi_d4 (
    .clk  (clk),
    .ena  (1'b1),
    .din  (b_hi_d3),
    .dout (b_hi_d4)
  );

  ////////////////////////////////////////
  // limb products and cascade adds
  ////////////////////////////////////////

  // p0 = lo*lo, p1 adds hi*lo at weight 2^17,
  // p2 adds lo*hi at the same weight, p3 adds hi*hi at 2^34
  always_ff @(posedge clk) begin
    m0_q <= a_lo_d1 * b_lo_d1;
    p0_q <= m0_q;

    m1_q <= a_hi_d2 * b_lo_d2;
    p1_q <= 43'(m1_q) + 43'(p0_q[33:mult_pkg::LIMB_LO]);

    m2_q <= a_lo_d3 * b_hi_d3;
    p2_q <= 44'(p1_q) + 44'(m2_q);

    m3_q <= a_hi_d4 * b_hi_d4;
    p3_q <= 36'(m3_q + 43'(p2_q[43:mult_pkg::LIMB_LO]));
  end

  ////////////////////////////////////////
  // output alignment
  ////////////////////////////////////////

  // low slice retired after p0, three flops to line up
  shift_reg #(
    .WIDTH (mult_pkg::LIMB_LO),
    .DEPTH (2)
  ) shift_reg_dout_l (
    .clk  (clk),
    .ena  (1'b1),
    .din  (p0_q[mult_pkg::LIMB_LO-1:0]),
    .dout (dout[16:0])
  );

  shift_reg #(
    .WIDTH (mult_pkg::LIMB_LO),
    .DEPTH (0)
  ) shift_reg_dout_m (
    .clk  (clk),
    .ena  (1'b1),
    .din  (p2_q[mult_pkg::LIMB_LO-1:0]),
    .dout (dout[33:17])
  );

  assign dout[69:34] = p3_q;

endmodule

// File: logic/mult_core_stage.sv
/*
 * Multiply stage: runs the limb multiplier and carries valid, mode and
 * tag alongside it, then drives the product interface.
 */

`timescale 1ns/10ps

module mult_core_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  input  mult_pkg::opa_t       opa,
  input  mult_pkg::opb_t       opb,
  input  mult_pkg::mult_mode_e mode,
  input  mult_pkg::tag_t       tag,
  mult_product_if.source       prod_out
);

  localparam int SIDE_W = $bits(mult_pkg::mult_mode_e) + $bits(mult_pkg::tag_t);

  logic [mult_pkg::MULT_LATENCY-1:0] valid_pipe_q;
  logic [SIDE_W-1:0]                 side_d;
  logic [SIDE_W-1:0]                 side_q;

  math_mult_35 math_mult_35_i (
    .clk  (clk),
    .dina (opa),
    .dinb (opb),
    .dout (prod_out.product)
  );

  // valid pipe matches the multiplier stage count
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_pipe_q <= '0;
    end else begin
      valid_pipe_q <= {valid_pipe_q[mult_pkg::MULT_LATENCY-2:0], in_valid};
    end
  end

  ////////////////////////////////////////
  // sideband delay, mode and tag
  ////////////////////////////////////////

  assign side_d = {mode, tag};

  shift_reg #(
    .WIDTH (SIDE_W),
    .DEPTH (mult_pkg::MULT_LATENCY - 1)
  ) shift_reg_side (
    .clk  (clk),
    .ena  (1'b1),
    .din  (side_d),
    .dout (side_q)
  );

  assign prod_out.valid = valid_pipe_q[mult_pkg::MULT_LATENCY-1];
  assign prod_out.mode  = mult_pkg::mult_mode_e'(side_q[SIDE_W-1:mult_pkg::TAG_W]);
  assign prod_out.tag   = side_q[mult_pkg::TAG_W-1:0];

  // sideband delay and valid pipe must stay aligned
  mode_known_on_valid: assert property (
    @(posedge clk) disable iff (reset)
    prod_out.valid |-> !$isunknown(prod_out.mode)
  );

endmodule

// File: logic/mult_pipe_top.sv
/*
 * Top level of the scaled multiplier pipeline: 42x35 multiply, then
 * mode-selected scaling with rounding and 48-bit saturation.
 * Fixed latency of 7, no back-pressure, one result per input strobe.
 */

`timescale 1ns/10ps

module mult_pipe_top (
  input  logic                 clk,
  input  logic                 reset,
  // sample input
  input  logic                 in_valid,
  input  mult_pkg::opa_t       opa,
  input  mult_pkg::opb_t       opb,
  input  mult_pkg::mult_mode_e mode,
  input  mult_pkg::tag_t       tag,
  // result output
  output logic                 out_valid,
  output mult_pkg::result_t    result,
  output logic                 sat,
  output mult_pkg::tag_t       out_tag
);

  mult_product_if prod_if ();

  ////////////////////////////////////////
  // multiply stage
  ////////////////////////////////////////

  mult_core_stage mult_core_stage_i (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .opa      (opa),
    .opb      (opb),
    .mode     (mode),
    .tag      (tag),
    .prod_out (prod_if.source)
  );

  ////////////////////////////////////////
  // round and saturate stage
  ////////////////////////////////////////

  mult_round_sat mult_round_sat_i (
    .clk       (clk),
    .reset     (reset),
    .prod_in   (prod_if.sink),
    .out_valid (out_valid),
    .result    (result),
    .sat       (sat),
    .out_tag   (out_tag)
  );

endmodule

// File: logic/mult_pkg.sv
/*
 * Shared widths, limb split points, latencies and the mode opcode for
 * the pipelined 42x35 multiplier with scaling, rounding and saturation.
 */

package mult_pkg;

  ////////////////////////////////////////
  // operand and result widths
  ////////////////////////////////////////

  localparam int OPA_W  = 42;
  localparam int OPB_W  = 35;
  localparam int PROD_W = 70;
  localparam int RES_W  = 48;
  localparam int TAG_W  = 8;

  // limb split, shared by both operands at the low end
  localparam int LIMB_LO  = 17;
  localparam int OPA_HI_W = OPA_W - LIMB_LO;
  localparam int OPB_HI_W = OPB_W - LIMB_LO;

  // right shifts applied by the fixed-point modes
  localparam int SHIFT_Q17 = 17;
  localparam int SHIFT_Q34 = 34;

  ////////////////////////////////////////
  // pipeline latencies
  ////////////////////////////////////////

  localparam int MULT_LATENCY  = 6;
  localparam int ROUND_LATENCY = 1;
  localparam int PIPE_LATENCY  = MULT_LATENCY + ROUND_LATENCY;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic [OPA_W-1:0]  opa_t;
  typedef logic [OPB_W-1:0]  opb_t;
  typedef logic [PROD_W-1:0] product_t;
  typedef logic [RES_W-1:0]  result_t;
  typedef logic [TAG_W-1:0]  tag_t;

  typedef enum logic [1:0] {
    MODE_RAW       = 2'd0,
    MODE_ROUND_Q17 = 2'd1,
    MODE_TRUNC_Q34 = 2'd2,
    MODE_ROUND_Q34 = 2'd3
  } mult_mode_e;

endpackage

// File: logic/mult_product_if.sv
/*
 * Product bundle between the multiply stage and the rounding stage.
 * Valid is a one-cycle strobe per sample, no handshake.
 */

`timescale 1ns/10ps

interface mult_product_if;

  logic                  valid;
  mult_pkg::product_t    product;
  mult_pkg::mult_mode_e  mode;
  mult_pkg::tag_t        tag;

  // driven by the multiply stage
  modport source (
    output valid,
    output product,
    output mode,
    output tag
  );

  // consumed by the rounding stage
  modport sink (
    input valid,
    input product,
    input mode,
    input tag
  );

endinterface

// File: logic/mult_round_sat.sv
/*
 * Rounding stage: scales the product by mode, rounds half up where the
 * mode asks for it, saturates to 48 bits and registers the result.
 */

`timescale 1ns/10ps

module mult_round_sat (
  input  logic             clk,
  input  logic             reset,
  mult_product_if.sink     prod_in,
  output logic             out_valid,
  output mult_pkg::result_t result,
  output logic             sat,
  output mult_pkg::tag_t   out_tag
);

  // one spare bit above the product for the rounding carry
  logic [mult_pkg::PROD_W:0] extended;
  logic [mult_pkg::PROD_W:0] scaled;
  logic                      overflow;

  ////////////////////////////////////////
  // scale and round
  ////////////////////////////////////////

  always_comb begin
    extended = {1'b0, prod_in.product};
    case (prod_in.mode)
      mult_pkg::MODE_RAW: begin
        scaled = extended;
      end
      mult_pkg::MODE_ROUND_Q17: begin
        scaled = (extended + ((mult_pkg::PROD_W + 1)'(1) << (mult_pkg::SHIFT_Q17 - 1)))
                 >> mult_pkg::SHIFT_Q17;
      end
      mult_pkg::MODE_TRUNC_Q34: begin
        scaled = extended >> mult_pkg::SHIFT_Q34;
      end
      mult_pkg::MODE_ROUND_Q34: begin
        scaled = (extended + ((mult_pkg::PROD_W + 1)'(1) << (mult_pkg::SHIFT_Q34 - 1)))
                 >> mult_pkg::SHIFT_Q34;
      end
      default: begin
        scaled = extended;
      end
    endcase
    // anything above bit 47 means the result does not fit
    overflow = |scaled[mult_pkg::PROD_W:mult_pkg::RES_W];
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      sat       <= 1'b0;
    end else begin
      out_valid <= prod_in.valid;
      if (prod_in.valid) begin
        sat <= overflow;
      end
    end
  end

  // payload holds between samples
  always_ff @(posedge clk) begin
    if (prod_in.valid) begin
      result  <= overflow ? '1 : scaled[mult_pkg::RES_W-1:0];
      out_tag <= prod_in.tag;
    end
  end

  sat_gives_all_ones: assert property (
    @(posedge clk) disable iff (reset)
    sat |-> (&result)
  );

  // one result per product, exactly one cycle later
  valid_one_cycle: assert property (
    @(posedge clk) disable iff (reset)
    out_valid == $past(prod_in.valid)
  );

endmodule

// File: logic/shift_reg.sv
/*
 * Delay line of DEPTH+1 enabled registers, no reset.
 * Used for operand limbs, partial product alignment and sideband.
 */

`timescale 1ns/10ps

module shift_reg #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 0
) (
  input  logic             clk,
  input  logic             ena,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  // stage 0 takes din, last stage drives dout
  logic [WIDTH-1:0] stage_q [DEPTH+1];

  always_ff @(posedge clk) begin
    if (ena) begin
      stage_q[0] <= din;
      for (int i = 1; i <= DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign dout = stage_q[DEPTH];

endmodule
